// ==== list.f ====
src/alu_cfg_pkg.sv
src/alu_uop_pkg.sv
src/alu_addsub.sv
src/alu_shift.sv
src/alu_lane.sv
src/alu_uop_fifo.sv
src/alu_dispatch.sv
src/vector_alu_top.sv
tb/vector_alu_asserts.sv
tb/vector_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module vector_alu_tb -f list.f -o vector_alu_sim &&
  { ./obj_dir/vector_alu_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
  grep -qx "No errors" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }

// ==== src/alu_addsub.sv ====
`timescale 1ns/1ns

module alu_addsub (
  input  alu_cfg_pkg::vreg_t a,
  input  alu_cfg_pkg::vreg_t b,
  input  logic               sub,
  input  alu_uop_pkg::sew_e  sew,
  output alu_cfg_pkg::vreg_t sum
);

  alu_cfg_pkg::vreg_t              b_eff;
  logic [alu_cfg_pkg::vlen/8-1:0]  cout;

  // a - b done as a + ~b + 1
  assign b_eff = sub ? ~b : b;

  // one 8-bit adder per byte, chained inside an element
  for (genvar i = 0; i < alu_cfg_pkg::vlen / 8; i++) begin : g_byte
    logic       elem_lo;
    logic       cin;
    logic [8:0] byte_sum;

    // byte starts a new element at the selected width
    assign elem_lo = (sew == alu_uop_pkg::sew8) ||
                     ((sew == alu_uop_pkg::sew16) && (i % 2 == 0)) ||
                     (i % 4 == 0);

    if (i == 0) begin : g_first
      // lowest byte always begins an element
      assign cin = sub;
    end else begin : g_next
      // carry stops at element boundaries, sub injects the +1 there
      assign cin = elem_lo ? sub : cout[i-1];
    end

    assign byte_sum = {1'b0, a[8*i +: 8]} + {1'b0, b_eff[8*i +: 8]} + {8'd0, cin};

    assign sum[8*i +: 8] = byte_sum[7:0];
    // carry out of the top byte wraps away
    assign cout[i]       = byte_sum[8];
  end

endmodule

// ==== src/alu_cfg_pkg.sv ====
package alu_cfg_pkg;

  // lane count, the dispatch logic is written for two
  localparam int num_alu = 2;

  // vector register width in bits
  localparam int vlen = 64;

  // reservation station entries, power of two so pointers wrap freely
  localparam int fifo_depth = 8;

  // one full vector register value
  typedef logic [vlen-1:0] vreg_t;

  // architectural vector register number
  typedef logic [4:0] vreg_idx_t;

  // reorder buffer tag
  typedef logic [3:0] rob_tag_t;

  // fifo occupancy, 0 to fifo_depth
  typedef logic [3:0] fifo_cnt_t;

endpackage

// ==== src/alu_dispatch.sv ====
`timescale 1ns/1ns

module alu_dispatch (
  // clock and reset only reach the bound checkers
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  alu_uop_pkg::alu_uop_t [alu_cfg_pkg::num_alu-1:0]    head_uop,
  input  logic                                                empty,
  input  logic                                                almost_empty,
  output logic [alu_cfg_pkg::num_alu-1:0]                     pop,
  output logic [alu_cfg_pkg::num_alu-1:0]                     result_valid,
  output alu_uop_pkg::alu_result_t [alu_cfg_pkg::num_alu-1:0] result,
  input  logic [alu_cfg_pkg::num_alu-1:0]                     result_ready
);

  logic [alu_cfg_pkg::num_alu-1:0] uop_valid;
  logic                            pop_all;

  // lane 0 sees the oldest entry
  assign uop_valid[0] = ~empty;
  // lane 1 needs at least two entries
  assign uop_valid[1] = ~(empty | almost_empty);

  // all or nothing, any valid lane without ready stalls both
  assign pop_all = ~|(uop_valid & ~result_ready);

  assign pop = uop_valid & {alu_cfg_pkg::num_alu{pop_all}};

  // lanes finish in the same cycle, so a pop is a retiring result
  assign result_valid = pop;

  // one lane per head entry
  for (genvar i = 0; i < alu_cfg_pkg::num_alu; i++) begin : g_lane
    alu_lane u_lane (
      .uop    (head_uop[i]),
      .result (result[i])
    );
  end

endmodule

// ==== src/alu_lane.sv ====
`timescale 1ns/1ns

module alu_lane (
  input  alu_uop_pkg::alu_uop_t    uop,
  output alu_uop_pkg::alu_result_t result
);

  alu_cfg_pkg::vreg_t sum;
  alu_cfg_pkg::vreg_t shifted;
  alu_cfg_pkg::vreg_t data;

  // add and sub share one adder, vs2 minus vs1 for sub
  alu_addsub u_addsub (
    .a   (uop.vs2_data),
    .b   (uop.vs1_data),
    .sub (uop.op == alu_uop_pkg::op_sub),
    .sew (uop.sew),
    .sum (sum)
  );

  // vs2 shifted by per element amounts from vs1
  alu_shift u_shift (
    .data    (uop.vs2_data),
    .amt     (uop.vs1_data),
    .op      (uop.op),
    .sew     (uop.sew),
    .shifted (shifted)
  );

  // result select, bitwise ops need no element split
  always_comb begin
    case (uop.op)
      alu_uop_pkg::op_add,
      alu_uop_pkg::op_sub: data = sum;
      alu_uop_pkg::op_and: data = uop.vs2_data & uop.vs1_data;
      alu_uop_pkg::op_or:  data = uop.vs2_data | uop.vs1_data;
      alu_uop_pkg::op_xor: data = uop.vs2_data ^ uop.vs1_data;
      default:             data = shifted;
    endcase
  end

  // tag and destination ride along untouched
  always_comb begin
    result.rob_tag = uop.rob_tag;
    result.vd      = uop.vd;
    result.data    = data;
  end

endmodule

// ==== src/alu_shift.sv ====
`timescale 1ns/1ns

module alu_shift (
  input  alu_cfg_pkg::vreg_t   data,
  input  alu_cfg_pkg::vreg_t   amt,
  input  alu_uop_pkg::alu_op_e op,
  input  alu_uop_pkg::sew_e    sew,
  output alu_cfg_pkg::vreg_t   shifted
);

  // results for 8, 16 and 32 bit elements
  alu_cfg_pkg::vreg_t sll_res [3];
  alu_cfg_pkg::vreg_t sr_res  [3];
  logic [1:0]         w_sel;

  // w is log2 of element width minus 3
  for (genvar w = 0; w < 3; w++) begin : g_width
    for (genvar e = 0; e < alu_cfg_pkg::vlen / (8 << w); e++) begin : g_elem
      logic [(8 << w)-1:0] elem;
      logic [w+2:0]        sh;
      logic                fill;

      assign elem = data[e*(8 << w) +: (8 << w)];
      // only the low log2(width) amount bits count
      assign sh   = amt[e*(8 << w) +: (w + 3)];
      // srl runs through the same shifter with a zero fill
      assign fill = (op == alu_uop_pkg::op_sra) & elem[(8 << w)-1];

      assign sll_res[w][e*(8 << w) +: (8 << w)] = elem << sh;
      assign sr_res[w][e*(8 << w) +: (8 << w)]  = (8 << w)'($signed({fill, elem}) >>> sh);
    end
  end

  // width select
  always_comb begin
    case (sew)
      alu_uop_pkg::sew16: w_sel = 2'd1;
      alu_uop_pkg::sew32: w_sel = 2'd2;
      default:            w_sel = 2'd0;
    endcase
  end

  // left shift has its own path, both right shifts share one
  assign shifted = (op == alu_uop_pkg::op_sll) ? sll_res[w_sel] : sr_res[w_sel];

endmodule

// ==== src/alu_uop_fifo.sv ====
`timescale 1ns/1ns

module alu_uop_fifo (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             push,
  input  alu_uop_pkg::alu_uop_t                            uop,
  output logic                                             full,
  input  logic [alu_cfg_pkg::num_alu-1:0]                  pop,
  output alu_uop_pkg::alu_uop_t [alu_cfg_pkg::num_alu-1:0] head_uop,
  output logic                                             empty,
  output logic                                             almost_empty
);

  // entry index, wraps at fifo_depth
  typedef logic [$clog2(alu_cfg_pkg::fifo_depth)-1:0] ptr_t;

  alu_uop_pkg::alu_uop_t  mem [alu_cfg_pkg::fifo_depth];
  ptr_t                   wr_ptr;
  ptr_t                   rd_ptr;
  ptr_t                   rd_ptr_p1;
  alu_cfg_pkg::fifo_cnt_t count;
  alu_cfg_pkg::fifo_cnt_t pop_cnt;
  logic                   push_ok;

  // level flags
  assign full         = (count == alu_cfg_pkg::fifo_cnt_t'(alu_cfg_pkg::fifo_depth));
  assign empty        = (count == '0);
  assign almost_empty = (count == alu_cfg_pkg::fifo_cnt_t'(1));

  // push while full is dropped
  assign push_ok = push & ~full;

  // dispatch never pops lane 1 alone, so this is the number of entries leaving
  assign pop_cnt = alu_cfg_pkg::fifo_cnt_t'(pop[0]) + alu_cfg_pkg::fifo_cnt_t'(pop[1]);

  // two oldest entries, oldest on lane 0
  assign rd_ptr_p1   = rd_ptr + ptr_t'(1);
  assign head_uop[0] = mem[rd_ptr];
  assign head_uop[1] = mem[rd_ptr_p1];

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= uop;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      // advance past every popped entry
      rd_ptr <= rd_ptr + ptr_t'(pop_cnt);
      count  <= count + alu_cfg_pkg::fifo_cnt_t'(push_ok) - pop_cnt;
    end
  end

endmodule

// ==== src/alu_uop_pkg.sv ====
package alu_uop_pkg;

  // alu opcodes
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_sll = 3'd2,
    op_srl = 3'd3,
    op_sra = 3'd4,
    op_and = 3'd5,
    op_or  = 3'd6,
    op_xor = 3'd7
  } alu_op_e;

  // selected element width
  typedef enum logic [1:0] {
    sew8  = 2'd0,
    sew16 = 2'd1,
    sew32 = 2'd2
  } sew_e;

  // micro-op as held in the reservation station
  // result is vs2 op vs1, shift amounts come from vs1
  typedef struct packed {
    alu_op_e                op;
    sew_e                   sew;
    alu_cfg_pkg::vreg_idx_t vd;
    alu_cfg_pkg::vreg_t     vs1_data;
    alu_cfg_pkg::vreg_t     vs2_data;
    alu_cfg_pkg::rob_tag_t  rob_tag;
  } alu_uop_t;

  // lane result handed to the rob
  typedef struct packed {
    alu_cfg_pkg::rob_tag_t  rob_tag;
    alu_cfg_pkg::vreg_idx_t vd;
    alu_cfg_pkg::vreg_t     data;
  } alu_result_t;

endpackage

// ==== src/vector_alu_top.sv ====
`timescale 1ns/1ns

module vector_alu_top (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                push,
  input  alu_uop_pkg::alu_uop_t                               uop,
  output logic                                                full,
  output logic [alu_cfg_pkg::num_alu-1:0]                     result_valid,
  output alu_uop_pkg::alu_result_t [alu_cfg_pkg::num_alu-1:0] result,
  input  logic [alu_cfg_pkg::num_alu-1:0]                     result_ready
);

  // fifo to dispatch
  alu_uop_pkg::alu_uop_t [alu_cfg_pkg::num_alu-1:0] head_uop;
  logic                                             empty;
  logic                                             almost_empty;
  logic [alu_cfg_pkg::num_alu-1:0]                  pop;

  // reservation station
  alu_uop_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .uop          (uop),
    .full         (full),
    .pop          (pop),
    .head_uop     (head_uop),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  // two lanes, results straight to the rob
  alu_dispatch u_dispatch (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_uop     (head_uop),
    .empty        (empty),
    .almost_empty (almost_empty),
    .pop          (pop),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

endmodule

// ==== tb/vector_alu_asserts.sv ====
`timescale 1ns/1ns

module vector_alu_asserts (
  input logic                            clk,
  input logic                            rst_n,
  input logic [alu_cfg_pkg::num_alu-1:0] pop,
  input logic [alu_cfg_pkg::num_alu-1:0] result_valid,
  input logic                            empty,
  input logic                            almost_empty
);

  // count of failed checks, polled from the testbench
  int unsigned violations = 0;

  // lane 1 only leaves together with lane 0
  a_pop_in_order: assert property (@(posedge clk) disable iff (!rst_n) pop[1] |-> pop[0])
    else begin
      violations++;
      $error("lane 1 popped without lane 0");
    end

  // nothing leaves an empty fifo
  a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) |pop |-> !empty)
    else begin
      violations++;
      $error("pop while the fifo is empty");
    end

  // single entry, lane 1 stays quiet
  a_one_entry: assert property (@(posedge clk) disable iff (!rst_n)
                                almost_empty |-> !result_valid[1])
    else begin
      violations++;
      $error("lane 1 valid with one entry held");
    end

endmodule

// ==== tb/vector_alu_tb.sv ====
`timescale 1ns/1ns

module vector_alu_tb;

  // one table row, exp_data worked out by hand
  typedef struct packed {
    alu_uop_pkg::alu_op_e   op;
    alu_uop_pkg::sew_e      sew;
    alu_cfg_pkg::vreg_t     vs1;
    alu_cfg_pkg::vreg_t     vs2;
    alu_cfg_pkg::vreg_idx_t vd;
    alu_cfg_pkg::rob_tag_t  rob_tag;
    alu_cfg_pkg::vreg_t     exp_data;
  } row_t;

  localparam int num_rows     = 16;
  localparam int reset_cycles = 10;
  // reset, a generous stall allowance per row, then drain
  localparam int max_cycles   = reset_cycles + 20 * num_rows + 70;

  logic                                                clk = 1'b0;
  logic                                                rst_n;
  logic                                                push;
  alu_uop_pkg::alu_uop_t                               uop;
  logic                                                full;
  logic [alu_cfg_pkg::num_alu-1:0]                     result_valid;
  alu_uop_pkg::alu_result_t [alu_cfg_pkg::num_alu-1:0] result;
  logic [alu_cfg_pkg::num_alu-1:0]                     result_ready = 2'b11;

  row_t                            rows [num_rows];
  alu_uop_pkg::alu_result_t        got_q [$];
  alu_uop_pkg::alu_result_t        got;
  integer                          seed        = 32'h6441;
  // 0 all lanes ready, 1 none, 2 random per lane
  int                              ready_mode  = 0;
  int                              check_idx   = 0;
  int                              cycle_count = 0;
  // entries that have landed in the fifo
  int                              push_cnt    = 0;
  int                              idle;
  logic                            dual_seen   = 1'b0;
  logic [alu_cfg_pkg::num_alu-1:0] exp_valid;

  vector_alu_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .uop          (uop),
    .full         (full),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  bind alu_dispatch vector_alu_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop          (pop),
    .result_valid (result_valid),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(string what, logic [63:0] got_val, logic [63:0] exp_val);
    $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got_val, exp_val);
    $display("Errors found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_problem(string msg);
    $display("%0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "run aborted");
  endtask

  // lanes the rob should see valid for a given fifo level and ready
  function automatic logic [alu_cfg_pkg::num_alu-1:0] expected_valid(
    int held, logic [alu_cfg_pkg::num_alu-1:0] ready);
    logic [alu_cfg_pkg::num_alu-1:0] want;
    if (held == 0) begin
      want = 2'b00;
    end else if (held == 1) begin
      want = 2'b01;
    end else begin
      want = 2'b11;
    end
    // one missing ready holds every lane
    if ((want & ~ready) != 2'b00) begin
      want = 2'b00;
    end
    return want;
  endfunction

  // full is checked after the previous push has landed
  task automatic push_row(input int idx);
    @(negedge clk);
    while (full) @(negedge clk);
    @(posedge clk);
    push <= 1'b1;
    uop  <= '{rows[idx].op, rows[idx].sew, rows[idx].vd, rows[idx].vs1, rows[idx].vs2,
              rows[idx].rob_tag};
    @(posedge clk);
    push <= 1'b0;
  endtask

  // rob ready per lane
  always @(posedge clk) begin
    case (ready_mode)
      0:       result_ready <= 2'b11;
      1:       result_ready <= 2'b00;
      default: result_ready <= 2'($random(seed));
    endcase
  end

  // never pushed while full, so every push lands
  always @(posedge clk) begin
    if (push) begin
      push_cnt <= push_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      report_problem("timeout, not every result came back from the DUT");
    end
  end

  // rob model, outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      assert (dut.u_dispatch.u_asserts.violations == 0)
        else report_problem("a dispatch assertion fired");
      // held entries are the landed pushes not yet retired
      exp_valid = expected_valid(push_cnt - check_idx, result_ready);
      assert (result_valid == exp_valid)
        else report_mismatch("result_valid", 64'(result_valid), 64'(exp_valid));
      if (result_valid == 2'b11) begin
        dual_seen <= 1'b1;
      end
      // lane 0 holds the older result
      for (int i = 0; i < alu_cfg_pkg::num_alu; i++) begin
        if (result_valid[i]) begin
          got_q.push_back(result[i]);
        end
      end
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        assert (check_idx < num_rows)
          else report_problem("a result came back after the last table row");
        assert (got.data == rows[check_idx].exp_data)
          else report_mismatch($sformatf("row %0d data", check_idx), got.data,
                               rows[check_idx].exp_data);
        assert (got.vd == rows[check_idx].vd)
          else report_mismatch($sformatf("row %0d vd", check_idx), 64'(got.vd),
                               64'(rows[check_idx].vd));
        assert (got.rob_tag == rows[check_idx].rob_tag)
          else report_mismatch($sformatf("row %0d rob_tag", check_idx), 64'(got.rob_tag),
                               64'(rows[check_idx].rob_tag));
        check_idx++;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    push  = 1'b0;
    uop   = '0;
    // carries must stop at every element edge
    rows[0]  = '{alu_uop_pkg::op_add, alu_uop_pkg::sew8, 64'h0101_0180_FF01_0101,
                 64'h01FF_7F80_0102_0304, 5'd1, 4'h0, 64'h0200_8000_0003_0405};
    rows[1]  = '{alu_uop_pkg::op_add, alu_uop_pkg::sew16, 64'h0001_0001_1111_0001,
                 64'h00FF_FFFF_1234_7FFF, 5'd2, 4'h1, 64'h0100_0000_2345_8000};
    rows[2]  = '{alu_uop_pkg::op_add, alu_uop_pkg::sew32, 64'h0000_0001_0000_0001,
                 64'h0000_00FF_FFFF_FFFF, 5'd3, 4'h2, 64'h0000_0100_0000_0000};
    rows[3]  = '{alu_uop_pkg::op_sub, alu_uop_pkg::sew8, 64'h0101_0106_01FF_0201,
                 64'h0010_8005_FF00_0203, 5'd4, 4'h3, 64'hFF0F_7FFF_FE01_0002};
    rows[4]  = '{alu_uop_pkg::op_sub, alu_uop_pkg::sew16, 64'h0001_0001_0001_0001,
                 64'h0000_1000_0100_8000, 5'd5, 4'h4, 64'hFFFF_0FFF_00FF_7FFF};
    rows[5]  = '{alu_uop_pkg::op_sub, alu_uop_pkg::sew32, 64'h0000_0001_0000_0678,
                 64'h0000_0000_1234_5678, 5'd6, 4'h5, 64'hFFFF_FFFF_1234_5000};
    // amounts carry junk above the low log2 width bits
    rows[6]  = '{alu_uop_pkg::op_sll, alu_uop_pkg::sew8, 64'h0001_0207_0809_0F03,
                 64'h0101_0101_8181_FFFF, 5'd7, 4'h6, 64'h0102_0480_8102_80F8};
    rows[7]  = '{alu_uop_pkg::op_srl, alu_uop_pkg::sew16, 64'h0001_0004_001F_0010,
                 64'h8000_F0F0_FFFF_1234, 5'd8, 4'h7, 64'h4000_0F0F_0001_1234};
    rows[8]  = '{alu_uop_pkg::op_sra, alu_uop_pkg::sew16, 64'h0001_0004_001F_0010,
                 64'h8000_F0F0_FFFF_1234, 5'd9, 4'h8, 64'hC000_FF0F_FFFF_1234};
    rows[9]  = '{alu_uop_pkg::op_srl, alu_uop_pkg::sew8, 64'h0707_0404_0109_0302,
                 64'h807F_F010_8101_FF40, 5'd10, 4'h9, 64'h0100_0F01_4000_1F10};
    rows[10] = '{alu_uop_pkg::op_sra, alu_uop_pkg::sew8, 64'h0707_0404_0109_0302,
                 64'h807F_F010_8101_FF40, 5'd11, 4'hA, 64'hFF00_FF01_C000_FF10};
    rows[11] = '{alu_uop_pkg::op_srl, alu_uop_pkg::sew32, 64'h0000_0021_0000_001F,
                 64'h8000_0000_FFFF_FFFF, 5'd12, 4'hB, 64'h4000_0000_0000_0001};
    rows[12] = '{alu_uop_pkg::op_sra, alu_uop_pkg::sew32, 64'h0000_0021_0000_001F,
                 64'h8000_0000_FFFF_FFFF, 5'd13, 4'hC, 64'hC000_0000_FFFF_FFFF};
    rows[13] = '{alu_uop_pkg::op_and, alu_uop_pkg::sew8, 64'h0FF0_FF00_A5A5_FFFF,
                 64'hF0F0_1234_FFFF_0000, 5'd29, 4'hD, 64'h00F0_1200_A5A5_0000};
    rows[14] = '{alu_uop_pkg::op_or, alu_uop_pkg::sew16, 64'h0FF0_FF00_A5A5_FFFF,
                 64'hF0F0_1234_FFFF_0000, 5'd30, 4'hE, 64'hFFF0_FF34_FFFF_FFFF};
    rows[15] = '{alu_uop_pkg::op_xor, alu_uop_pkg::sew32, 64'h0FF0_FF00_A5A5_FFFF,
                 64'hF0F0_1234_FFFF_0000, 5'd31, 4'hF, 64'hFF00_ED34_5A5A_FFFF};
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    // quiet after reset
    repeat (3) begin
      @(negedge clk);
      assert (result_valid == '0)
        else report_mismatch("result_valid before any push", 64'(result_valid), 64'(0));
      assert (!full)
        else report_mismatch("full before any push", 64'(full), 64'(0));
    end
    // rob stalls until the fifo fills up
    ready_mode = 1;
    for (int r = 0; r < alu_cfg_pkg::fifo_depth; r++) begin
      push_row(r);
    end
    @(negedge clk);
    assert (full)
      else report_mismatch("full after filling the fifo", 64'(full), 64'(1));
    // both lanes drain together
    ready_mode = 0;
    repeat (3) @(negedge clk);
    ready_mode = 2;
    for (int r = alu_cfg_pkg::fifo_depth; r < num_rows; r++) begin
      idle = $random(seed) & 3;
      repeat (idle) @(posedge clk);
      push_row(r);
    end
    while (check_idx < num_rows) @(posedge clk);
    // a few more cycles to catch duplicates
    repeat (4) @(posedge clk);
    assert (dual_seen)
      else report_problem("no cycle retired two results at once");
    if (check_idx == num_rows) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "results missing at the end");
    end
  end

endmodule
